/* project.f */
+incdir+verilog
verilog/decl_check_pkg.sv
verilog/decl_checker.sv
verilog/decl_check_regs.sv
verilog/decl_check_top.sv
verification/decl_check_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module decl_check_tb -o decl_check_sim
output=$(./obj_dir/decl_check_sim)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

/* verification/decl_check_tb.sv */
`timescale 1ns/100ps
`include "decl_check_defines.svh"

module decl_check_tb import decl_check_pkg::*; ();

	localparam int WAIT_LIMIT = 8;
	localparam int EV_ACCEPT  = 8;

	// Reference model states
	localparam int M_START    = 0;
	localparam int M_KEYWORD  = 1;
	localparam int M_AFTER_KW = 2;
	localparam int M_GAP      = 3;
	localparam int M_NAME     = 4;
	localparam int M_TRAIL    = 5;
	localparam int M_SKIP     = 6;

	logic         clk;
	logic         reset;
	char_t        ch;
	reg_addr_t    reg_addr;
	logic         reg_wr;
	reg_data_t    reg_wdata;
	logic         reg_rd;
	reg_data_t    reg_rdata;
	decl_result_t result;

	int errors;
	int checks;
	int cur_idx;
	int got_idx[$];
	int got_ev[$];
	int exp_idx[$];
	int exp_ev[$];

	// Test table, one entry per index
	string t_name[$];
	string t_text[$];
	string t_exp[$];
	bit    t_en[$];
	int    t_pause[$];

	decl_check_top uut (
		.clk       (clk),
		.reset     (reset),
		.ch        (ch),
		.reg_addr  (reg_addr),
		.reg_wr    (reg_wr),
		.reg_wdata (reg_wdata),
		.reg_rd    (reg_rd),
		.reg_rdata (reg_rdata),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic bit name_start(input char_t c);
		return (c >= "a" && c <= "z") || (c >= "A" && c <= "Z") || c == "_";
	endfunction

	function automatic bit name_char(input char_t c);
		return name_start(c) || (c >= "0" && c <= "9");
	endfunction

	// Table code A means an accept and a digit means a reject reason
	function automatic int event_code(input char_t c);
		return (c == "A") ? EV_ACCEPT : int'(c) - 48;
	endfunction

	task automatic add_test(input string name, input string text, input string exp,
			input bit en, input int pause_at);
		t_name.push_back(name);
		t_text.push_back(text);
		t_exp.push_back(exp);
		t_en.push_back(en);
		t_pause.push_back(pause_at);
	endtask

	//////////////////////////////////////////////////
	// Reference model of the declaration grammar
	//////////////////////////////////////////////////

	task automatic model_decls(input string text);
		string kw = "int";
		string name;
		int    st;
		int    kw_pos;
		int    why;
		char_t c;
		exp_idx.delete();
		exp_ev.delete();
		st = M_START;
		kw_pos = 0;
		for (int k = 0; k < text.len(); k++) begin
			c = text[k];
			why = 0;
			case (st)
				M_START: begin
					if (c == "i") begin
						st = M_KEYWORD;
						kw_pos = 1;
					end else if (c != " ") begin
						why = int'(REASON_BAD_KEYWORD);
					end
				end
				M_KEYWORD: begin
					if (c != kw[kw_pos]) begin
						why = int'(REASON_BAD_KEYWORD);
					end else begin
						kw_pos++;
						st = (kw_pos == 3) ? M_AFTER_KW : M_KEYWORD;
					end
				end
				M_AFTER_KW: begin
					if (c == " ") begin
						st = M_GAP;
					end else begin
						why = int'(REASON_NO_SPACE);
					end
				end
				M_GAP: begin
					if (name_start(c)) begin
						st = M_NAME;
						name = $sformatf("%c", c);
					end else if (c != " ") begin
						why = int'(REASON_BAD_IDENT_START);
					end
				end
				M_NAME: begin
					if (name_char(c)) begin
						name = $sformatf("%s%c", name, c);
					end else if ((c == " " || c == ";") && name == "int") begin
						why = int'(REASON_RESERVED_IDENT);
					end else if (c == " ") begin
						st = M_TRAIL;
					end else if (c == ";") begin
						exp_idx.push_back(k);
						exp_ev.push_back(EV_ACCEPT);
						st = M_START;
					end else begin
						why = int'(REASON_BAD_IDENT_CHAR);
					end
				end
				M_TRAIL: begin
					if (c == ";") begin
						exp_idx.push_back(k);
						exp_ev.push_back(EV_ACCEPT);
						st = M_START;
					end else if (c != " ") begin
						why = int'(REASON_BAD_IDENT_CHAR);
					end
				end
				default: begin
					if (c == ";") begin
						st = M_START;
					end
				end
			endcase
			if (why != 0) begin
				exp_idx.push_back(k);
				exp_ev.push_back(why);
				st = (c == ";") ? M_START : M_SKIP;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Drivers and checks
	//////////////////////////////////////////////////

	// Record the verdict for the previous character, then drive the next one
	task automatic step_char(input char_t c, input int idx);
		@(negedge clk);
		if (result.accept) begin
			got_idx.push_back(cur_idx);
			got_ev.push_back(EV_ACCEPT);
		end
		if (result.reject) begin
			got_idx.push_back(cur_idx);
			got_ev.push_back(int'(result.reason));
		end
		ch = c;
		cur_idx = idx;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
	endtask

	task automatic drive_write(input reg_addr_t addr, input reg_data_t data);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
	endtask

	task automatic check_reg(input string name, input reg_addr_t addr, input int expected);
		step_char(" ", -1);
		reg_rd = 1'b1;
		reg_addr = addr;
		step_char(" ", -1);
		checks++;
		if (reg_rdata !== reg_data_t'(expected)) begin
			errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, reg_rdata);
		end
	endtask

	task automatic wait_pulses(input string name, input int want);
		int waited;
		waited = 0;
		while (got_ev.size() < want && waited < WAIT_LIMIT) begin
			step_char(" ", -1);
			waited++;
		end
		if (got_ev.size() < want) begin
			errors++;
			$display("%s: timed out waiting for %0d pulses, only %0d arrived",
				name, want, got_ev.size());
		end
		// Catch late or extra pulses
		step_char(" ", -1);
		step_char(" ", -1);
	endtask

	task automatic compare_events(input string name, input string tab_exp, input bit use_table);
		checks++;
		if (use_table && tab_exp.len() != got_ev.size()) begin
			errors++;
			$display("mismatch %s: expected %0d pulses from table, actual %0d",
				name, tab_exp.len(), got_ev.size());
		end else if (use_table) begin
			for (int k = 0; k < got_ev.size(); k++) begin
				if (event_code(tab_exp[k]) != got_ev[k]) begin
					errors++;
					$display("mismatch %s: pulse %0d expected code %0d, actual %0d",
						name, k, event_code(tab_exp[k]), got_ev[k]);
				end
			end
		end
		if (exp_ev.size() != got_ev.size()) begin
			errors++;
			$display("mismatch %s: expected %0d pulses, actual %0d",
				name, exp_ev.size(), got_ev.size());
		end else begin
			for (int k = 0; k < got_ev.size(); k++) begin
				if (exp_ev[k] != got_ev[k] || exp_idx[k] != got_idx[k]) begin
					errors++;
					$display("mismatch %s: expected code %0d after char %0d, actual %0d after %0d",
						name, exp_ev[k], exp_idx[k], got_ev[k], got_idx[k]);
				end
			end
		end
	endtask

	task automatic run_test(input string name, input string text, input string tab_exp,
			input bit en, input int pause_at, input bit use_table);
		if (got_ev.size() != 0) begin
			errors++;
			$display("%s: a pulse appeared between declarations", name);
		end
		got_idx.delete();
		got_ev.delete();
		model_decls(en ? text : "");
		if (!en) begin
			step_char(" ", -1);
			drive_write(`DC_REG_CTRL, 16'h0000);
		end
		for (int k = 0; k < text.len(); k++) begin
			step_char(text[k], k);
			if (k == pause_at) begin
				drive_write(`DC_REG_CTRL, 16'h0000);
				// Junk that the paused checker never sees
				for (int g = 0; g < 3; g++) begin
					step_char("#", -1);
				end
				drive_write(`DC_REG_CTRL, 16'h0001);
			end
		end
		if (!en) begin
			step_char(" ", -1);
			drive_write(`DC_REG_CTRL, 16'h0001);
		end
		wait_pulses(name, exp_ev.size());
		compare_events(name, tab_exp, use_table);
		got_idx.delete();
		got_ev.delete();
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] seed;
		string       text;
		string       alphabet;
		int          len;
		int          n_acc;
		int          n_rej;
		int          last_why;
		errors = 0;
		checks = 0;
		cur_idx = -1;
		reset = 1'b1;
		ch = " ";
		reg_addr = '0;
		reg_wr = 1'b0;
		reg_wdata = '0;
		reg_rd = 1'b0;
		alphabet = "inta_0 ;#";
		repeat (5) @(negedge clk);
		reset = 1'b0;
		step_char(" ", -1);
		drive_write(`DC_REG_CTRL, 16'h0001);

		add_test("simple", "int x;", "A", 1'b1, -1);
		add_test("spaces", "  int  _a9 ;", "A", 1'b1, -1);
		add_test("name starts with int", "int intx;", "A", 1'b1, -1);
		add_test("name is prefix of int", "int in;", "A", 1'b1, -1);
		add_test("bad keyword", "itn a;", "1", 1'b1, -1);
		add_test("semicolon in idle", "; int k;", "1A", 1'b1, -1);
		add_test("space in keyword", "in t a;", "1", 1'b1, -1);
		add_test("no space", "int;", "2", 1'b1, -1);
		add_test("bad ident start", "int 9a;", "3", 1'b1, -1);
		add_test("bad ident char", "int a#;", "4", 1'b1, -1);
		add_test("reserved ident", "int int;", "5", 1'b1, -1);
		add_test("resync", "int 9 junk x; int y;", "3A", 1'b1, -1);
		add_test("disabled", "int z;", "", 1'b0, -1);
		add_test("paused", "int pq;", "A", 1'b1, 4);

		n_acc = 0;
		n_rej = 0;
		last_why = int'(REASON_NONE);
		for (int i = 0; i < t_name.size(); i++) begin
			run_test(t_name[i], t_text[i], t_exp[i], t_en[i], t_pause[i], 1'b1);
			for (int k = 0; k < t_exp[i].len(); k++) begin
				if (t_exp[i][k] == "A") begin
					n_acc++;
				end else begin
					n_rej++;
					last_why = event_code(t_exp[i][k]);
				end
			end
		end
		check_reg("accept count", `DC_REG_ACCEPT, n_acc);
		check_reg("reject count", `DC_REG_REJECT, n_rej);
		check_reg("last reason", `DC_REG_REASON, last_why);

		// Clear with enable kept on
		step_char(" ", -1);
		drive_write(`DC_REG_CTRL, 16'h0003);
		check_reg("ctrl after clear", `DC_REG_CTRL, 1);
		check_reg("accept after clear", `DC_REG_ACCEPT, 0);
		check_reg("reject after clear", `DC_REG_REJECT, 0);
		check_reg("reason after clear", `DC_REG_REASON, int'(REASON_NONE));

		// Random strings end in a semicolon so the checker finishes idle
		seed = 32'h3c2a;
		n_acc = 0;
		n_rej = 0;
		last_why = int'(REASON_NONE);
		for (int r = 0; r < 200; r++) begin
			seed = lcg_next(seed);
			if (seed[20]) begin
				text = "int ";
			end else begin
				text = "";
			end
			len = int'(seed[19:16]);
			for (int k = 0; k < len; k++) begin
				seed = lcg_next(seed);
				text = $sformatf("%s%c", text, alphabet[int'(seed[23:16]) % 9]);
			end
			text = $sformatf("%s;", text);
			run_test($sformatf("random %0d", r), text, "", 1'b1, -1, 1'b0);
			for (int k = 0; k < exp_ev.size(); k++) begin
				if (exp_ev[k] == EV_ACCEPT) begin
					n_acc++;
				end else begin
					n_rej++;
					last_why = exp_ev[k];
				end
			end
		end
		check_reg("random accept count", `DC_REG_ACCEPT, n_acc);
		check_reg("random reject count", `DC_REG_REJECT, n_rej);
		check_reg("random last reason", `DC_REG_REASON, last_why);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* verilog/decl_check_defines.svh */
`ifndef DECL_CHECK_DEFINES_SVH
`define DECL_CHECK_DEFINES_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

`define DC_COUNT_W 16
`define DC_DATA_W  16
`define DC_ADDR_W  2

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

`define DC_REG_CTRL   2'd0
`define DC_REG_ACCEPT 2'd1
`define DC_REG_REJECT 2'd2
`define DC_REG_REASON 2'd3

`endif

/* verilog/decl_check_pkg.sv */
`include "decl_check_defines.svh"

package decl_check_pkg;

	// Plain vector types
	typedef logic [7:0]              char_t;
	typedef logic [`DC_COUNT_W-1:0]  count_t;
	typedef logic [`DC_DATA_W-1:0]   reg_data_t;
	typedef logic [`DC_ADDR_W-1:0]   reg_addr_t;

	// Why a declaration was thrown out
	typedef enum logic [2:0] {
		REASON_NONE            = 3'd0,
		REASON_BAD_KEYWORD     = 3'd1,
		REASON_NO_SPACE        = 3'd2,
		REASON_BAD_IDENT_START = 3'd3,
		REASON_BAD_IDENT_CHAR  = 3'd4,
		REASON_RESERVED_IDENT  = 3'd5
	} reason_t;

	// Recognizer states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_KW_I,
		ST_KW_N,
		ST_KW_T,
		ST_GAP,
		ST_IDENT,
		ST_IDENT_I,
		ST_IDENT_N,
		ST_IDENT_T,
		ST_TAIL,
		ST_SKIP
	} decl_state_t;

	// One-cycle verdict for a finished declaration
	typedef struct packed {
		logic    accept;
		logic    reject;
		reason_t reason;
	} decl_result_t;

endpackage

/* verilog/decl_check_regs.sv */
`timescale 1ns/100ps
`include "decl_check_defines.svh"

module decl_check_regs import decl_check_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  reg_addr_t    reg_addr,
	input  logic         reg_wr,
	input  reg_data_t    reg_wdata,
	input  logic         reg_rd,
	output reg_data_t    reg_rdata,
	input  decl_result_t result,
	output logic         enable
);

	localparam count_t COUNT_MAX = '1;

	count_t  accept_cnt;
	count_t  reject_cnt;
	reason_t last_reason;
	logic    ctrl_wr;
	logic    clear;

	//////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////

	assign ctrl_wr = reg_wr && (reg_addr == `DC_REG_CTRL);
	// Bit 1 of CTRL is a self-clearing command
	assign clear   = ctrl_wr && reg_wdata[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 1'b0;
		end else if (ctrl_wr) begin
			enable <= reg_wdata[0];
		end
	end

	//////////////////////////////////////////////////
	// Counters and last reason
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			accept_cnt <= '0;
		end else if (result.accept && accept_cnt != COUNT_MAX) begin
			accept_cnt <= accept_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			reject_cnt <= '0;
		end else if (result.reject && reject_cnt != COUNT_MAX) begin
			reject_cnt <= reject_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			last_reason <= REASON_NONE;
		end else if (result.reject) begin
			last_reason <= result.reason;
		end
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	// Data shows up the cycle after the strobe and holds until the next read
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_rdata <= '0;
		end else if (reg_rd) begin
			case (reg_addr)
				`DC_REG_CTRL: begin
					reg_rdata <= reg_data_t'(enable);
				end
				`DC_REG_ACCEPT: begin
					reg_rdata <= reg_data_t'(accept_cnt);
				end
				`DC_REG_REJECT: begin
					reg_rdata <= reg_data_t'(reject_cnt);
				end
				`DC_REG_REASON: begin
					reg_rdata <= reg_data_t'(last_reason);
				end
				default: begin
					reg_rdata <= '0;
				end
			endcase
		end
	end

endmodule

/* verilog/decl_check_top.sv */
`timescale 1ns/100ps

module decl_check_top import decl_check_pkg::*; (
	input  logic         clk,
	input  logic         reset,

	// Character stream
	input  char_t        ch,

	// Register port
	input  reg_addr_t    reg_addr,
	input  logic         reg_wr,
	input  reg_data_t    reg_wdata,
	input  logic         reg_rd,
	output reg_data_t    reg_rdata,

	// Per-declaration verdict
	output decl_result_t result
);

	logic enable;

	//////////////////////////////////////////////////
	// Recognizer
	//////////////////////////////////////////////////

	decl_checker u_checker (
		.clk    (clk),
		.reset  (reset),
		.enable (enable),
		.ch     (ch),
		.result (result)
	);

	//////////////////////////////////////////////////
	// Control and status
	//////////////////////////////////////////////////

	// Counts the verdicts and owns the enable bit
	decl_check_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.reg_addr  (reg_addr),
		.reg_wr    (reg_wr),
		.reg_wdata (reg_wdata),
		.reg_rd    (reg_rd),
		.reg_rdata (reg_rdata),
		.result    (result),
		.enable    (enable)
	);

endmodule

/* verilog/decl_checker.sv */
`timescale 1ns/100ps

module decl_checker import decl_check_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         enable,
	input  char_t        ch,
	output decl_result_t result
);

	//////////////////////////////////////////////////
	// Character classes
	//////////////////////////////////////////////////

	logic is_alpha;
	logic is_digit;
	logic is_under;
	logic is_space;
	logic is_semi;
	logic is_ident_start;
	logic is_ident_char;

	assign is_alpha       = (ch >= "a" && ch <= "z") || (ch >= "A" && ch <= "Z");
	assign is_digit       = (ch >= "0" && ch <= "9");
	assign is_under       = (ch == "_");
	assign is_space       = (ch == " ");
	assign is_semi        = (ch == ";");
	assign is_ident_start = is_alpha || is_under;
	assign is_ident_char  = is_ident_start || is_digit;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	decl_state_t state;
	decl_state_t state_next;
	logic        accept_next;
	logic        fail;
	reason_t     fail_reason;

	always_comb begin
		state_next  = state;
		accept_next = 1'b0;
		fail        = 1'b0;
		fail_reason = REASON_NONE;

		case (state)
			ST_IDLE: begin
				// Leading spaces are fine, a bare semicolon is not
				if (is_space) begin
					state_next = ST_IDLE;
				end else if (ch == "i") begin
					state_next = ST_KW_I;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_BAD_KEYWORD;
				end
			end

			ST_KW_I: begin
				if (ch == "n") begin
					state_next = ST_KW_N;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_BAD_KEYWORD;
				end
			end

			ST_KW_N: begin
				if (ch == "t") begin
					state_next = ST_KW_T;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_BAD_KEYWORD;
				end
			end

			ST_KW_T: begin
				// Keyword must be followed by at least one space
				if (is_space) begin
					state_next = ST_GAP;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_NO_SPACE;
				end
			end

			ST_GAP: begin
				if (is_space) begin
					state_next = ST_GAP;
				end else if (ch == "i") begin
					state_next = ST_IDENT_I;
				end else if (is_ident_start) begin
					state_next = ST_IDENT;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_BAD_IDENT_START;
				end
			end

			ST_IDENT_I, ST_IDENT_N, ST_IDENT_T: begin
				// Name still looks like the keyword
				if (state == ST_IDENT_I && ch == "n") begin
					state_next = ST_IDENT_N;
				end else if (state == ST_IDENT_N && ch == "t") begin
					state_next = ST_IDENT_T;
				end else if (is_ident_char) begin
					state_next = ST_IDENT;
				end else if (state == ST_IDENT_T && (is_space || is_semi)) begin
					fail        = 1'b1;
					fail_reason = REASON_RESERVED_IDENT;
				end else if (is_space) begin
					state_next = ST_TAIL;
				end else if (is_semi) begin
					state_next  = ST_IDLE;
					accept_next = 1'b1;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_BAD_IDENT_CHAR;
				end
			end

			ST_IDENT: begin
				if (is_ident_char) begin
					state_next = ST_IDENT;
				end else if (is_space) begin
					state_next = ST_TAIL;
				end else if (is_semi) begin
					state_next  = ST_IDLE;
					accept_next = 1'b1;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_BAD_IDENT_CHAR;
				end
			end

			ST_TAIL: begin
				// Only spaces may sit between the name and the semicolon
				if (is_space) begin
					state_next = ST_TAIL;
				end else if (is_semi) begin
					state_next  = ST_IDLE;
					accept_next = 1'b1;
				end else begin
					fail        = 1'b1;
					fail_reason = REASON_BAD_IDENT_CHAR;
				end
			end

			ST_SKIP: begin
				if (is_semi) begin
					state_next = ST_IDLE;
				end
			end

			default: begin
				state_next = ST_IDLE;
			end
		endcase

		// A rejecting semicolon already closes the declaration
		if (fail) begin
			state_next = is_semi ? ST_IDLE : ST_SKIP;
		end
	end

	//////////////////////////////////////////////////
	// State and result registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= ST_IDLE;
			result.accept <= 1'b0;
			result.reject <= 1'b0;
			result.reason <= REASON_NONE;
		end else if (enable) begin
			state         <= state_next;
			result.accept <= accept_next;
			result.reject <= fail;
			result.reason <= fail_reason;
		end else begin
			// Hold state and keep pulses low while the stream is paused
			result.accept <= 1'b0;
			result.reject <= 1'b0;
			result.reason <= REASON_NONE;
		end
	end

endmodule
